// File: source/sxt_pkg.sv
/* Sample extraction rotator definitions */

`default_nettype none

package sxt_pkg;

  // ====================
  // Sizes
  // ====================

  // Polynomial size and coefficient width
  localparam int N_COEF     = 64;
  localparam int COEF_W     = 16;

  // Coefficients per output word with one RAM bank per coefficient
  localparam int COEF_NB    = 4;
  // Lanes handled by one rotation half
  localparam int HALF_NB    = 2;
  // Output words per command
  localparam int WORD_NB    = N_COEF / COEF_NB;

  // Row address inside one bank
  localparam int ROW_W      = 4;
  // Full coefficient RAM address
  localparam int ADDR_W     = 6;
  // Body b spans 2*N_COEF for the negacyclic wrap
  localparam int BODY_W     = 7;
  // Bank index
  localparam int BANK_W     = 2;

  // Join output FIFO
  localparam int FIFO_DEPTH = 4;

  // ====================
  // Types
  // ====================

  // One output word with lane 0 in the low bits
  typedef logic [COEF_NB-1:0][COEF_W-1:0] coef_word_t;

  // Per lane control
  typedef struct packed {
    logic [BANK_W-1:0] bank;  // Bank that holds the source coefficient
    logic              neg;   // Negate mod 2^COEF_W
  } lane_ctrl_t;

  // Read request from the read stage
  // Coefficient i sits at address N_COEF-1-i
  // Bank is address mod COEF_NB and row is address / COEF_NB
  typedef struct packed {
    logic                          en;
    logic [COEF_NB-1:0][ROW_W-1:0] row;   // Row address per bank
    lane_ctrl_t [COEF_NB-1:0]      lane;  // Control per output lane
    logic                          last;  // Last word of the command
  } rd_req_t;

  // Output of one rotation half
  typedef struct packed {
    logic                          vld;
    logic                          last;
    logic [HALF_NB-1:0][COEF_W-1:0] coef;
  } half_t;

endpackage

`default_nettype wire

// File: source/sxt_read.sv
/* Sample extraction read stage */

`timescale 1ns/1ps
`default_nettype none

module sxt_read
  import sxt_pkg::*;
(
  input  logic              clk,
  input  logic              s_rst_n,

  // Command
  input  logic              cmd_vld_i,
  output logic              cmd_rdy_o,
  input  logic [BODY_W-1:0] cmd_body_i,

  // One pulse per word leaving the join FIFO
  input  logic              credit_ret_i,

  // Request to RAM and rotation halves
  output rd_req_t           rd_req_o
);

  typedef logic [$clog2(WORD_NB)-1:0]      word_cnt_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

  logic                           busy_q;
  logic [BODY_W-1:0]              body_q;
  word_cnt_t                      word_cnt_q;
  credit_t                        credit_q;

  logic                           accept;
  logic                           issue;

  // Per lane position in the 2*N_COEF ring and reversed RAM address
  logic [COEF_NB-1:0][BODY_W-1:0] src_pos;
  logic [COEF_NB-1:0][ADDR_W-1:0] src_addr;

  // ====================
  // Control
  // ====================

  assign cmd_rdy_o = ~busy_q;
  assign accept    = cmd_vld_i & cmd_rdy_o;
  // A word returned this cycle frees its slot right away
  assign issue     = busy_q & ((credit_q != '0) | credit_ret_i);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy_q     <= 1'b0;
      word_cnt_q <= '0;
      credit_q   <= credit_t'(FIFO_DEPTH);
    end else begin
      if (accept) begin
        busy_q     <= 1'b1;
        word_cnt_q <= '0;
      end else if (issue) begin
        word_cnt_q <= word_cnt_q + 1'b1;
        // Back to idle once the last word is out
        if (rd_req_o.last) begin
          busy_q <= 1'b0;
        end
      end
      credit_q <= credit_q - credit_t'(issue) + credit_t'(credit_ret_i);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      body_q <= cmd_body_i;
    end
  end

  // ====================
  // Address generation
  // ====================

  always_comb begin
    rd_req_o      = '0;
    rd_req_o.en   = issue;
    rd_req_o.last = (word_cnt_q == word_cnt_t'(WORD_NB-1));
    for (int l = 0; l < COEF_NB; l++) begin
      // s = (j + b) mod 2*N_COEF through the width wrap
      src_pos[l]  = body_q + BODY_W'({word_cnt_q, BANK_W'(l)});
      // Reversed storage
      src_addr[l] = ADDR_W'(N_COEF-1) - src_pos[l][ADDR_W-1:0];
      rd_req_o.lane[l].bank = src_addr[l][BANK_W-1:0];
      rd_req_o.lane[l].neg  = (src_pos[l] >= BODY_W'(N_COEF));
      // Consecutive addresses hit distinct banks with one row per bank
      rd_req_o.row[src_addr[l][BANK_W-1:0]] = src_addr[l][ADDR_W-1:BANK_W];
    end
  end

  // Returns never outrun issued reads
  a_credit_range: assert property (@(posedge clk) disable iff (!s_rst_n)
    credit_q <= credit_t'(FIFO_DEPTH))
    else $error("credit counter out of range");

endmodule

`default_nettype wire

// File: source/sxt_gram.sv
/* Banked coefficient RAM */

`timescale 1ns/1ps
`default_nettype none

module sxt_gram
  import sxt_pkg::*;
(
  input  logic              clk,

  // Write port
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [COEF_W-1:0] wr_data_i,

  // Read port, one row per bank
  input  rd_req_t           rd_req_i,
  output coef_word_t        rd_data_o
);

  localparam int ROW_NB = N_COEF / COEF_NB;

  // One array per bank
  logic [COEF_W-1:0] bank_mem [COEF_NB][ROW_NB];

  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  wr_row;

  // ====================
  // Address decode
  // ====================

  // Low bits pick the bank
  assign wr_bank = wr_addr_i[BANK_W-1:0];
  assign wr_row  = wr_addr_i[ADDR_W-1:BANK_W];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      bank_mem[wr_bank][wr_row] <= wr_data_i;
    end
    // All banks read in parallel with 1 cycle latency
    if (rd_req_i.en) begin
      for (int b = 0; b < COEF_NB; b++) begin
        rd_data_o[b] <= bank_mem[b][rd_req_i.row[b]];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/sxt_rot.sv
/* Rotation half */

`timescale 1ns/1ps
`default_nettype none

module sxt_rot
  import sxt_pkg::*;
#(
  parameter int HALF_ID   = 0,  // Which pair of lanes
  parameter int INPUT_DLY = 0   // Extra cycles before the select
)
(
  input  logic       clk,
  input  logic       s_rst_n,

  input  rd_req_t    rd_req_i,
  input  coef_word_t rd_data_i,

  output half_t      half_o
);

  typedef struct packed {
    logic                     vld;
    logic                     last;
    lane_ctrl_t [HALF_NB-1:0] lane;
    coef_word_t               data;
  } rot_in_t;

  logic                            ctrl_vld_q;
  logic                            ctrl_last_q;
  lane_ctrl_t [HALF_NB-1:0]        ctrl_lane_q;

  rot_in_t                         rot_in;
  rot_in_t                         sel_in;

  logic [HALF_NB-1:0][COEF_W-1:0]  sel_coef;
  logic [HALF_NB-1:0][COEF_W-1:0]  neg_coef;

  // Controls wait for the RAM
  always_ff @(posedge clk) begin
    ctrl_vld_q  <= rd_req_i.en;
    ctrl_last_q <= rd_req_i.last;
    ctrl_lane_q <= rd_req_i.lane[HALF_ID*HALF_NB +: HALF_NB];
    if (!s_rst_n) begin
      ctrl_vld_q <= 1'b0;
    end
  end

  assign rot_in = {ctrl_vld_q, ctrl_last_q, ctrl_lane_q, rd_data_i};

  // ====================
  // Input delay
  // ====================
  generate
    if (INPUT_DLY == 0) begin : gen_no_dly
      assign sel_in = rot_in;
    end else begin : gen_dly
      rot_in_t pipe_q [INPUT_DLY];

      always_ff @(posedge clk) begin
        pipe_q[0] <= rot_in;
        for (int d = 1; d < INPUT_DLY; d++) begin
          pipe_q[d] <= pipe_q[d-1];
        end
        if (!s_rst_n) begin
          for (int d = 0; d < INPUT_DLY; d++) begin
            pipe_q[d].vld <= 1'b0;
          end
        end
      end

      assign sel_in = pipe_q[INPUT_DLY-1];
    end
  endgenerate

  // ====================
  // Select and negate
  // ====================
  always_comb begin
    for (int l = 0; l < HALF_NB; l++) begin
      sel_coef[l] = sel_in.data[sel_in.lane[l].bank];
      // Negation mod 2^COEF_W
      neg_coef[l] = sel_in.lane[l].neg ? COEF_W'(0) - sel_coef[l] : sel_coef[l];
    end
  end

  always_ff @(posedge clk) begin
    half_o.vld  <= sel_in.vld;
    half_o.last <= sel_in.last;
    half_o.coef <= neg_coef;
    if (!s_rst_n) begin
      half_o.vld <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/sxt_join.sv
/* Half join and output FIFO */

`timescale 1ns/1ps
`default_nettype none

module sxt_join
  import sxt_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,

  // Half 0 arrives one cycle ahead of half 1
  input  half_t      half0_i,
  input  half_t      half1_i,

  // Output
  output logic       out_vld_o,
  input  logic       out_rdy_i,
  output coef_word_t out_data_o,
  output logic       out_last_o,

  // Back to the read stage
  output logic       credit_ret_o
);

  typedef struct packed {
    logic       last;
    coef_word_t data;
  } fifo_ent_t;

  typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

  half_t     half0_q;

  fifo_ent_t fifo_mem [FIFO_DEPTH];
  fifo_ent_t push_ent;
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      cnt_q;

  logic      push;
  logic      pop;
  logic      full;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(FIFO_DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  // ====================
  // Realign
  // ====================
  always_ff @(posedge clk) begin
    half0_q <= half0_i;
    if (!s_rst_n) begin
      half0_q.vld <= 1'b0;
    end
  end

  // Half 0 holds lanes 0 and 1
  assign push     = half0_q.vld;
  assign push_ent = {half1_i.last, half1_i.coef, half0_q.coef};

  // ====================
  // FIFO
  // ====================
  assign full         = (cnt_q == cnt_t'(FIFO_DEPTH));
  assign out_vld_o    = (cnt_q != '0);
  assign pop          = out_vld_o & out_rdy_i;
  assign credit_ret_o = pop;
  assign out_data_o   = fifo_mem[rd_ptr_q].data;
  assign out_last_o   = fifo_mem[rd_ptr_q].last;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= push_ent;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  // Both halves come from the same request stream
  a_halves_aligned: assert property (@(posedge clk) disable iff (!s_rst_n)
    (half0_q.vld == half1_i.vld) && (!half0_q.vld || (half0_q.last == half1_i.last)))
    else $error("rotation halves out of step");

  // Credits in the read stage bound the occupancy
  a_no_overflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    push |-> !full)
    else $error("join FIFO overflow");

endmodule

`default_nettype wire

// File: source/sxt_core.sv
/* Sample extraction rotator top */

`timescale 1ns/1ps
`default_nettype none

module sxt_core
  import sxt_pkg::*;
(
  input  logic              clk,
  input  logic              s_rst_n,

  // Command
  input  logic              cmd_vld_i,
  output logic              cmd_rdy_o,
  input  logic [BODY_W-1:0] cmd_body_i,

  // Coefficient write
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [COEF_W-1:0] wr_data_i,

  // Rotated words
  output logic              out_vld_o,
  input  logic              out_rdy_i,
  output coef_word_t        out_data_o,
  output logic              out_last_o
);

  rd_req_t    rd_req;
  coef_word_t rd_data;
  half_t      half0;
  half_t      half1;
  logic       credit_ret;

  // ====================
  // Read and RAM
  // ====================
  sxt_read u_sxt_read (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .cmd_vld_i    (cmd_vld_i),
    .cmd_rdy_o    (cmd_rdy_o),
    .cmd_body_i   (cmd_body_i),
    .credit_ret_i (credit_ret),
    .rd_req_o     (rd_req)
  );

  sxt_gram u_sxt_gram (
    .clk       (clk),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_req_i  (rd_req),
    .rd_data_o (rd_data)
  );

  // ====================
  // Rotation and join
  // ====================
  // Half 1 starts one cycle later
  sxt_rot #(.HALF_ID(0), .INPUT_DLY(0)) u_sxt_rot_h0 (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .rd_req_i  (rd_req),
    .rd_data_i (rd_data),
    .half_o    (half0)
  );

  sxt_rot #(.HALF_ID(1), .INPUT_DLY(1)) u_sxt_rot_h1 (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .rd_req_i  (rd_req),
    .rd_data_i (rd_data),
    .half_o    (half1)
  );

  sxt_join u_sxt_join (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .half0_i      (half0),
    .half1_i      (half1),
    .out_vld_o    (out_vld_o),
    .out_rdy_i    (out_rdy_i),
    .out_data_o   (out_data_o),
    .out_last_o   (out_last_o),
    .credit_ret_o (credit_ret)
  );

endmodule

`default_nettype wire

// File: testbench/tb_sxt_model.svh
/* Rotator reference model */

`ifndef TB_SXT_MODEL_SVH
`define TB_SXT_MODEL_SVH

// One expected output word
typedef struct packed {
  logic       last;
  coef_word_t data;
} exp_word_t;

// Copy of the polynomial as written to the DUT
logic [COEF_W-1:0] model_poly [N_COEF];
// Expected words with the oldest first
exp_word_t         exp_q [$];

// Coefficient i is stored reversed
function automatic logic [ADDR_W-1:0] model_addr(input int idx);
  return ADDR_W'(N_COEF - 1 - idx);
endfunction

// Output coefficient j of the negacyclic rotation by body
function automatic logic [COEF_W-1:0] model_coef(input int j, input int body);
  int                s;
  logic [COEF_W-1:0] v;
  s = (j + body) % (2 * N_COEF);
  v = model_poly[s % N_COEF];
  // Upper half of the ring flips the sign mod 2^16
  if (s >= N_COEF) begin
    v = COEF_W'((1 << COEF_W) - int'(v));
  end
  return v;
endfunction

// All words of one command into the queue
function automatic void model_push(input int body);
  exp_word_t w;
  for (int wi = 0; wi < WORD_NB; wi++) begin
    for (int l = 0; l < COEF_NB; l++) begin
      w.data[l] = model_coef(wi * COEF_NB + l, body);
    end
    w.last = (wi == WORD_NB - 1);
    exp_q.push_back(w);
  end
endfunction

`endif

// File: testbench/tb_sxt_core.sv
/* Rotator testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_sxt_core
  import sxt_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int DRV_DLY    = 1;
  // Accept edge to first transfer edge with no stall
  localparam int LATENCY    = 5;
  // 1 + 4 + 4 + 4 + 6 commands over all tests
  localparam int NUM_CMDS   = 19;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * WORD_NB * 20 + 500;

  logic              clk;
  logic              s_rst_n;
  logic              cmd_vld;
  logic              cmd_rdy;
  logic [BODY_W-1:0] cmd_body;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [COEF_W-1:0] wr_data;
  logic              out_vld;
  logic              out_rdy;
  coef_word_t        out_data;
  logic              out_last;

  integer seed;
  int     err_cnt = 0;
  int     chk_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     xfer_cnt = 0;
  int     cycle_cnt = 0;
  int     accept_cycle;
  bit     lat_pending = 1'b0;
  bit     gap_en = 1'b0;
  bit     gap_prev_vld = 1'b0;
  int     prev_xfer_cycle;
  bit     prev_last;
  bit     stall_en = 1'b0;

  `include "tb_sxt_model.svh"

  sxt_core u_sxt_core (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .cmd_vld_i  (cmd_vld),
    .cmd_rdy_o  (cmd_rdy),
    .cmd_body_i (cmd_body),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .out_vld_o  (out_vld),
    .out_rdy_i  (out_rdy),
    .out_data_o (out_data),
    .out_last_o (out_last)
  );

  // ====================
  // Clock and cycle count
  // ====================
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ====================
  // Helpers
  // ====================
  task automatic step();
    @(posedge clk);
    #DRV_DLY;
  endtask

  // Random polynomial through the reversed storage rule
  task automatic load_poly();
    for (int i = 0; i < N_COEF; i++) begin
      model_poly[i] = $random(seed);
      wr_en   = 1'b1;
      wr_addr = model_addr(i);
      wr_data = model_poly[i];
      step();
    end
    wr_en = 1'b0;
  endtask

  // Hold valid until the DUT takes the command
  task automatic send_cmd(input int body, input bit check_lat);
    model_push(body);
    cmd_vld  = 1'b1;
    cmd_body = BODY_W'(body);
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    accept_cycle = cycle_cnt;
    lat_pending  = check_lat;
    step();
    cmd_vld = 1'b0;
  endtask

  // Stray words get a few cycles to show up before the count
  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (LATENCY) step();
  endtask

  task automatic check_count(input int xfer_start, input int ncmd);
    chk_cnt++;
    assert (xfer_cnt - xfer_start == ncmd * WORD_NB) else begin
      $display("Mismatch at %0t: %0d words out, expected %0d", $time,
               xfer_cnt - xfer_start, ncmd * WORD_NB);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    if (err_cnt == err_start) begin
      pass_cnt++;
      $display("Test %0d (%s): ok", num, name);
    end else begin
      fail_cnt++;
      $display("Test %0d (%s): FAILED with %0d errors", num, name, err_cnt - err_start);
    end
  endtask

  // ====================
  // Output ready
  // ====================
  // Drawn at the falling edge and applied after the rising edge
  initial begin : rdy_drive
    integer draw;
    forever begin
      @(negedge clk);
      draw = stall_en ? $random(seed) : 1;
      step();
      out_rdy = draw[0];
    end
  end

  // ====================
  // Output checker
  // ====================
  // Sampled mid cycle before the transfer edge
  always @(negedge clk) begin : check_out
    exp_word_t exp_w;
    int        gap;
    if (s_rst_n && out_vld && out_rdy) begin
      chk_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("Error at %0t: output word arrived with no expected word left", $time);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        exp_w = exp_q.pop_front();
        chk_cnt++;
        assert (out_data == exp_w.data && out_last == exp_w.last) else begin
          $display("Mismatch at %0t: got %h last %b, expected %h last %b", $time,
                   out_data, out_last, exp_w.data, exp_w.last);
          err_cnt++;
        end
      end
      // First word after an idle accept
      if (lat_pending) begin
        chk_cnt++;
        assert (cycle_cnt - accept_cycle == LATENCY) else begin
          $display("Mismatch at %0t: latency %0d cycles, expected %0d", $time,
                   cycle_cnt - accept_cycle, LATENCY);
          err_cnt++;
        end
        lat_pending = 1'b0;
      end
      // One idle cycle between commands and none inside one
      if (gap_en && gap_prev_vld) begin
        gap = cycle_cnt - prev_xfer_cycle;
        chk_cnt++;
        assert (gap == (prev_last ? 2 : 1)) else begin
          $display("Mismatch at %0t: %0d cycles between words", $time, gap);
          err_cnt++;
        end
      end
      gap_prev_vld    = 1'b1;
      prev_xfer_cycle = cycle_cnt;
      prev_last       = out_last;
      xfer_cnt++;
    end
  end

  // ====================
  // Watchdog
  // ====================
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT did not finish the commands",
             WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // ====================
  // Stimulus
  // ====================
  initial begin : stimulus
    int err_start;
    int xfer_start;
    int body;
    seed     = 32'h302e;
    s_rst_n  = 1'b0;
    cmd_vld  = 1'b0;
    cmd_body = '0;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    out_rdy  = 1'b1;
    repeat (4) step();
    s_rst_n = 1'b1;

    // Idle state after reset
    err_start = err_cnt;
    @(negedge clk);
    chk_cnt++;
    assert (!out_vld && cmd_rdy) else begin
      $display("Mismatch at %0t: after reset out_vld %b cmd_rdy %b", $time, out_vld, cmd_rdy);
      err_cnt++;
    end
    step();
    report_test(1, "reset state", err_start);

    // Plain readout undoes the reversed storage
    err_start  = err_cnt;
    load_poly();
    xfer_start = xfer_cnt;
    send_cmd(0, 1'b1);
    drain();
    check_count(xfer_start, 1);
    report_test(2, "zero rotation", err_start);

    err_start  = err_cnt;
    xfer_start = xfer_cnt;
    for (int c = 0; c < 4; c++) begin
      body = $random(seed) & (N_COEF - 1);
      send_cmd(body, 1'b0);
    end
    drain();
    check_count(xfer_start, 4);
    report_test(3, "rotation below N", err_start);

    // Sign flips over the whole upper ring
    err_start  = err_cnt;
    xfer_start = xfer_cnt;
    for (int c = 0; c < 4; c++) begin
      body = N_COEF + ($random(seed) & (N_COEF - 1));
      send_cmd(body, 1'b0);
    end
    drain();
    check_count(xfer_start, 4);
    report_test(4, "rotation above N", err_start);

    err_start    = err_cnt;
    load_poly();
    xfer_start   = xfer_cnt;
    gap_prev_vld = 1'b0;
    gap_en       = 1'b1;
    for (int c = 0; c < 4; c++) begin
      body = $random(seed) & (2 * N_COEF - 1);
      send_cmd(body, 1'b0);
    end
    drain();
    gap_en = 1'b0;
    check_count(xfer_start, 4);
    report_test(5, "back to back", err_start);

    // Back-pressure through the credit loop
    err_start  = err_cnt;
    xfer_start = xfer_cnt;
    stall_en   = 1'b1;
    for (int c = 0; c < 6; c++) begin
      body = $random(seed) & (2 * N_COEF - 1);
      send_cmd(body, 1'b0);
    end
    drain();
    stall_en = 1'b0;
    check_count(xfer_start, 6);
    report_test(6, "random stalls", err_start);

    // Catch stray words
    repeat (10) step();
    $display("Tests: %0d passed, %0d failed, %0d checks, %0d errors",
             pass_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+testbench
source/sxt_pkg.sv
source/sxt_read.sv
source/sxt_gram.sv
source/sxt_rot.sv
source/sxt_join.sv
source/sxt_core.sv
testbench/tb_sxt_core.sv

// File: Bender.yml
package:
  name: sxt_core

sources:
  - files:
      - source/sxt_pkg.sv
      - source/sxt_read.sv
      - source/sxt_gram.sv
      - source/sxt_rot.sv
      - source/sxt_join.sv
      - source/sxt_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_sxt_core.sv
